//--- mem_and_mul.f
+incdir+include
source/mem_and_mul_pkg.sv
source/cmd_buffer.sv
source/row_store.sv
source/row_engine.sv
source/out_skid_buffer.sv
source/mem_and_mul.sv
tb/mem_and_mul_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds with Verilator, runs the testbench, then scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f mem_and_mul.f --top-module mem_and_mul_tb \
  -Mdir obj_dir -o mem_and_mul_sim > build.log 2>&1 \
  && ./obj_dir/mem_and_mul_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Result: failed"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log || { echo "Result: passed"; exit 0; }

//--- source/cmd_buffer.sv
`timescale 1ns/100ps

module cmd_buffer (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_and_mul_pkg::cmd_t cmd,
  input  logic                  cmd_is_ready,
  input  logic                  cmd_take,
  output logic                  cmd_can_receive,
  output mem_and_mul_pkg::cmd_t held_cmd,
  output logic                  held_valid
);

  logic accept;

  // Single slot, open only when empty
  assign cmd_can_receive = ~held_valid;
  assign accept          = cmd_is_ready & cmd_can_receive;

  always_ff @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (cmd_take) begin
      held_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_cmd <= cmd;
    end
  end

  // Engine never starts a command that is not held
  assert property (@(posedge clk) disable iff (reset) cmd_take |-> held_valid);

endmodule

//--- source/mem_and_mul.sv
`timescale 1ns/100ps

module mem_and_mul #(
  parameter int ROWS = 16
) (
  input  logic                   clk,
  input  logic                   reset,
  input  mem_and_mul_pkg::cmd_t  cmd,
  input  logic                   cmd_is_ready,
  output logic                   cmd_can_receive,
  input  mem_and_mul_pkg::word_t in_data,
  input  logic                   in_is_ready,
  output logic                   in_can_receive,
  output logic                   in_is_last,
  output mem_and_mul_pkg::word_t out_data,
  output logic                   out_is_ready,
  output logic                   out_is_last,
  input  logic                   out_can_receive
);

  localparam int idx_w = $clog2(ROWS);

  mem_and_mul_pkg::cmd_t    held_cmd;
  logic                     held_valid;
  logic                     cmd_take;

  logic                     rd_en;
  logic [idx_w-1:0]         rd_index;
  logic                     rd_sel_u;
  mem_and_mul_pkg::word_t   rd_word;
  mem_and_mul_pkg::u_word_t rd_u;
  logic                     wr_en;
  logic [idx_w-1:0]         wr_index;
  logic                     wr_sel_u;
  mem_and_mul_pkg::word_t   wr_word;
  mem_and_mul_pkg::u_word_t wr_u;

  logic                     push;
  logic                     push_last;
  mem_and_mul_pkg::word_t   push_word;

  cmd_buffer u_cmd_buffer (
    .clk             (clk),
    .reset           (reset),
    .cmd             (cmd),
    .cmd_is_ready    (cmd_is_ready),
    .cmd_take        (cmd_take),
    .cmd_can_receive (cmd_can_receive),
    .held_cmd        (held_cmd),
    .held_valid      (held_valid)
  );

  row_engine #(.ROWS(ROWS)) u_row_engine (
    .clk             (clk),
    .reset           (reset),
    .held_cmd        (held_cmd),
    .held_valid      (held_valid),
    .cmd_take        (cmd_take),
    .in_data         (in_data),
    .in_is_ready     (in_is_ready),
    .in_can_receive  (in_can_receive),
    .in_is_last      (in_is_last),
    .out_can_receive (out_can_receive),
    .rd_en           (rd_en),
    .rd_index        (rd_index),
    .rd_sel_u        (rd_sel_u),
    .rd_word         (rd_word),
    .rd_u            (rd_u),
    .wr_en           (wr_en),
    .wr_index        (wr_index),
    .wr_sel_u        (wr_sel_u),
    .wr_word         (wr_word),
    .wr_u            (wr_u),
    .push            (push),
    .push_last       (push_last),
    .push_word       (push_word)
  );

  row_store #(.ROWS(ROWS)) u_row_store (
    .clk      (clk),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_sel_u (rd_sel_u),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_sel_u (wr_sel_u),
    .wr_word  (wr_word),
    .wr_u     (wr_u),
    .rd_word  (rd_word),
    .rd_u     (rd_u)
  );

  out_skid_buffer u_out_skid_buffer (
    .clk             (clk),
    .reset           (reset),
    .push            (push),
    .push_last       (push_last),
    .push_word       (push_word),
    .out_can_receive (out_can_receive),
    .out_data        (out_data),
    .out_is_ready    (out_is_ready),
    .out_is_last     (out_is_last)
  );

endmodule

//--- source/mem_and_mul_pkg.sv
package mem_and_mul_pkg;

  localparam int lane_w   = 16;
  localparam int lanes    = 4;
  localparam int u_lane_w = 4;

  typedef logic [lane_w-1:0]         lane_t;
  typedef logic [lanes*lane_w-1:0]   word_t;
  typedef logic [lanes*u_lane_w-1:0] u_word_t;

  typedef enum logic [2:0] {
    in_c,
    in_u,
    add_c,
    enc_u,
    enc_u_min_c,
    dec_c,
    out_c,
    out_u
  } cmd_t;

  // Each 4-bit lane moves to the top of its 16-bit lane
  function automatic word_t encode_word(u_word_t u);
    word_t w;
    for (int i = 0; i < lanes; i++) begin
      w[i*lane_w +: lane_w] = lane_t'({u[i*u_lane_w +: u_lane_w], {(lane_w-u_lane_w){1'b0}}});
    end
    return w;
  endfunction

  // Rounds the top 5 bits of each lane down to 4
  function automatic u_word_t decode_word(word_t w);
    u_word_t           u;
    lane_t             l;
    logic [u_lane_w:0] top;
    for (int i = 0; i < lanes; i++) begin
      l   = w[i*lane_w +: lane_w];
      top = l[lane_w-1 -: u_lane_w+1] + 1'b1;
      u[i*u_lane_w +: u_lane_w] = top[u_lane_w:1];
    end
    return u;
  endfunction

endpackage

//--- source/out_skid_buffer.sv
`timescale 1ns/100ps

module out_skid_buffer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic                   push_last,
  input  mem_and_mul_pkg::word_t push_word,
  input  logic                   out_can_receive,
  output mem_and_mul_pkg::word_t out_data,
  output logic                   out_is_ready,
  output logic                   out_is_last
);

  logic [1:0]             buf_v;
  logic [1:0]             buf_last;
  mem_and_mul_pkg::word_t buf_data [2];

  logic [2:0]             m_v;
  logic [2:0]             m_last;
  mem_and_mul_pkg::word_t m_data [3];

  //////////////////////////////////////////////////
  // Merge held entries with the incoming word
  //////////////////////////////////////////////////

  always_comb begin
    m_v[0]    = buf_v[0] | push;
    m_v[1]    = buf_v[1] | (buf_v[0] & push);
    m_v[2]    = buf_v[0] & buf_v[1] & push;
    m_last[0] = buf_v[0] ? buf_last[0] : push_last;
    m_last[1] = buf_v[1] ? buf_last[1] : push_last;
    m_last[2] = push_last;
    m_data[0] = buf_v[0] ? buf_data[0] : push_word;
    m_data[1] = buf_v[1] ? buf_data[1] : push_word;
    m_data[2] = push_word;
  end

  // Head of the merged list goes out
  assign out_is_ready = out_can_receive & m_v[0];
  assign out_is_last  = out_is_ready & m_last[0];
  assign out_data     = m_data[0];

  // Shift by one when the head leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      buf_v <= 2'b00;
    end else begin
      buf_v <= out_can_receive ? m_v[2:1] : m_v[1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (out_can_receive) begin
      buf_last    <= m_last[2:1];
      buf_data[0] <= m_data[1];
      buf_data[1] <= m_data[2];
    end else begin
      buf_last    <= m_last[1:0];
      buf_data[0] <= m_data[0];
      buf_data[1] <= m_data[1];
    end
  end

  assert property (@(posedge clk) disable iff (reset) (buf_v[1] & ~out_can_receive) |-> ~push);

endmodule

//--- source/row_engine.sv
`timescale 1ns/100ps

module row_engine #(
  parameter  int ROWS  = 16,
  localparam int idx_w = $clog2(ROWS)
) (
  input  logic                     clk,
  input  logic                     reset,
  input  mem_and_mul_pkg::cmd_t    held_cmd,
  input  logic                     held_valid,
  output logic                     cmd_take,
  input  mem_and_mul_pkg::word_t   in_data,
  input  logic                     in_is_ready,
  output logic                     in_can_receive,
  output logic                     in_is_last,
  input  logic                     out_can_receive,
  output logic                     rd_en,
  output logic [idx_w-1:0]         rd_index,
  output logic                     rd_sel_u,
  input  mem_and_mul_pkg::word_t   rd_word,
  input  mem_and_mul_pkg::u_word_t rd_u,
  output logic                     wr_en,
  output logic [idx_w-1:0]         wr_index,
  output logic                     wr_sel_u,
  output mem_and_mul_pkg::word_t   wr_word,
  output mem_and_mul_pkg::u_word_t wr_u,
  output logic                     push,
  output logic                     push_last,
  output mem_and_mul_pkg::word_t   push_word
);

  localparam int lw = mem_and_mul_pkg::lane_w;

  typedef enum logic [1:0] {
    idle,
    run,
    drain
  } state_t;

  state_t                 state;
  mem_and_mul_pkg::cmd_t  cur_cmd;
  logic [idx_w-1:0]       row_idx;
  logic                   row_at_last;
  logic                   is_load;
  logic                   is_add;
  logic                   is_op;
  logic                   is_out;
  logic                   in_xfer;
  logic                   step;

  // Delay line, lines up with store data
  logic                   v1;
  logic                   v2;
  logic                   last1;
  logic                   last2;
  logic [idx_w-1:0]       idx1;
  logic [idx_w-1:0]       wr_idx;
  mem_and_mul_pkg::word_t data1;
  mem_and_mul_pkg::word_t data2;

  mem_and_mul_pkg::word_t enc_word;
  mem_and_mul_pkg::word_t lane_sum;
  mem_and_mul_pkg::word_t lane_diff;

  assign is_load = (cur_cmd == mem_and_mul_pkg::in_c) | (cur_cmd == mem_and_mul_pkg::in_u);
  assign is_add  = (cur_cmd == mem_and_mul_pkg::add_c);
  assign is_op   = (cur_cmd == mem_and_mul_pkg::enc_u) | (cur_cmd == mem_and_mul_pkg::enc_u_min_c)
                 | (cur_cmd == mem_and_mul_pkg::dec_c);
  assign is_out  = (cur_cmd == mem_and_mul_pkg::out_c) | (cur_cmd == mem_and_mul_pkg::out_u);

  assign cmd_take       = (state == idle) & held_valid;
  assign in_can_receive = (state == run) & (is_load | is_add);
  assign in_xfer        = in_can_receive & in_is_ready;
  assign row_at_last    = (row_idx == idx_w'(ROWS - 1));
  assign in_is_last     = in_can_receive & row_at_last;

  // add_c reads on input arrival, out reads only when the sink is open
  always_comb begin
    rd_en = 1'b0;
    if (state == run) begin
      if (is_add) begin
        rd_en = in_is_ready;
      end else if (is_out) begin
        rd_en = out_can_receive;
      end else begin
        rd_en = is_op;
      end
    end
  end

  assign rd_index = row_idx;
  assign rd_sel_u = (cur_cmd == mem_and_mul_pkg::enc_u) | (cur_cmd == mem_and_mul_pkg::out_u);
  assign step     = rd_en | in_xfer;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      row_idx <= '0;
      cur_cmd <= mem_and_mul_pkg::in_c;
    end else begin
      case (state)
        idle: begin
          if (cmd_take) begin
            state   <= run;
            row_idx <= '0;
            cur_cmd <= held_cmd;
          end
        end
        run: begin
          if (step) begin
            row_idx <= row_at_last ? '0 : row_idx + 1'b1;
            if (row_at_last) begin
              state <= is_load ? idle : drain;
            end
          end
        end
        drain: begin
          // Last write or push leaves the pipe
          if (v2 & last2) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= rd_en;
      v2 <= v1;
    end
  end

  always_ff @(posedge clk) begin
    last1  <= row_at_last;
    last2  <= last1;
    idx1   <= row_idx;
    wr_idx <= idx1;
    data1  <= in_data;
    data2  <= data1;
  end

  //////////////////////////////////////////////////
  // Lane arithmetic, mod 2^16
  //////////////////////////////////////////////////

  assign enc_word = mem_and_mul_pkg::encode_word(rd_u);

  always_comb begin
    for (int i = 0; i < mem_and_mul_pkg::lanes; i++) begin
      lane_sum[i*lw +: lw]  = rd_word[i*lw +: lw] + data2[i*lw +: lw];
      lane_diff[i*lw +: lw] = enc_word[i*lw +: lw] - rd_word[i*lw +: lw];
    end
  end

  always_comb begin
    case (cur_cmd)
      mem_and_mul_pkg::add_c:       wr_word = lane_sum;
      mem_and_mul_pkg::enc_u:       wr_word = enc_word;
      mem_and_mul_pkg::enc_u_min_c: wr_word = lane_diff;
      default:                      wr_word = in_data;
    endcase
  end

  // Loads write at the transfer edge, the rest two cycles after the read
  assign wr_en    = (in_xfer & is_load) | (v2 & (is_add | is_op));
  assign wr_index = is_load ? row_idx : wr_idx;
  assign wr_sel_u = (cur_cmd == mem_and_mul_pkg::in_u) | (cur_cmd == mem_and_mul_pkg::dec_c);
  assign wr_u     = (cur_cmd == mem_and_mul_pkg::dec_c) ? mem_and_mul_pkg::decode_word(rd_word)
                                                        : mem_and_mul_pkg::u_word_t'(in_data);

  assign push      = v2 & is_out;
  assign push_last = push & last2;
  assign push_word = (cur_cmd == mem_and_mul_pkg::out_u) ? mem_and_mul_pkg::word_t'(rd_u)
                                                         : rd_word;

  // Drain lasts two cycles even with the sink stalled
  assert property (@(posedge clk) disable iff (reset)
    $rose(state == drain) |=> (state == drain) ##1 (state == idle));

endmodule

//--- source/row_store.sv
`timescale 1ns/100ps

module row_store #(
  parameter  int ROWS  = 16,
  localparam int idx_w = $clog2(ROWS)
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     rd_en,
  input  logic [idx_w-1:0]         rd_index,
  input  logic                     rd_sel_u,
  input  logic                     wr_en,
  input  logic [idx_w-1:0]         wr_index,
  input  logic                     wr_sel_u,
  input  mem_and_mul_pkg::word_t   wr_word,
  input  mem_and_mul_pkg::u_word_t wr_u,
  output mem_and_mul_pkg::word_t   rd_word,
  output mem_and_mul_pkg::u_word_t rd_u
);

  mem_and_mul_pkg::word_t   c_mem [ROWS];
  mem_and_mul_pkg::u_word_t u_mem [ROWS];

  mem_and_mul_pkg::word_t   c_q1;
  mem_and_mul_pkg::u_word_t u_q1;
  logic                     c_v1;
  logic                     u_v1;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (wr_sel_u) begin
        u_mem[wr_index] <= wr_u;
      end else begin
        c_mem[wr_index] <= wr_word;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read path, two register stages
  //////////////////////////////////////////////////

  // u row comes with every read, C row unless rd_sel_u
  always_ff @(posedge clk) begin
    if (reset) begin
      c_v1 <= 1'b0;
      u_v1 <= 1'b0;
    end else begin
      c_v1 <= rd_en & ~rd_sel_u;
      u_v1 <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en & ~rd_sel_u) begin
      c_q1 <= c_mem[rd_index];
    end
    if (rd_en) begin
      u_q1 <= u_mem[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (c_v1) begin
      rd_word <= c_q1;
    end
    if (u_v1) begin
      rd_u <= u_q1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) wr_en |-> (int'(wr_index) < ROWS));

endmodule

//--- include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Model copies of C and u
localparam int model_rows = 16;

logic [63:0] model_c [model_rows];
logic [15:0] model_u [model_rows];

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// n bits, one step per bit
function automatic logic [63:0] lfsr_bits(inout logic [15:0] s, input int n);
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    s = lfsr_step(s);
    v = {v[62:0], s[0]};
  end
  return v;
endfunction

function automatic logic [63:0] ref_encode(input logic [15:0] u);
  logic [63:0] c;
  for (int i = 0; i < 4; i++) begin
    c[16*i +: 16] = {u[4*i +: 4], 12'h000};
  end
  return c;
endfunction

// Top 5 bits plus one, then halved
function automatic logic [15:0] ref_decode(input logic [63:0] c);
  logic [15:0] u;
  logic [4:0]  top;
  for (int i = 0; i < 4; i++) begin
    top = c[16*i+11 +: 5] + 5'd1;
    u[4*i +: 4] = top[4:1];
  end
  return u;
endfunction

`endif

//--- tb/mem_and_mul_tb.sv
`timescale 1ns/100ps

module mem_and_mul_tb;

  `include "tb_model.svh"

  localparam int cycle_limit = 8 * model_rows * 8 + 200;

  logic                   clk;
  logic                   reset;
  mem_and_mul_pkg::cmd_t  cmd;
  logic                   cmd_is_ready;
  logic                   cmd_can_receive;
  mem_and_mul_pkg::word_t in_data;
  logic                   in_is_ready;
  logic                   in_can_receive;
  logic                   in_is_last;
  mem_and_mul_pkg::word_t out_data;
  logic                   out_is_ready;
  logic                   out_is_last;
  logic                   out_can_receive;

  logic [15:0] lfsr_state;
  logic        toggle_out;
  int          value_errors;
  int          protocol_errors;
  int          cycles;

  // Expected output words, oldest first
  logic [63:0] exp_data [$];
  logic        exp_is_u [$];
  int          exp_row  [$];

  mem_and_mul #(.ROWS(model_rows)) uut (
    .clk             (clk),
    .reset           (reset),
    .cmd             (cmd),
    .cmd_is_ready    (cmd_is_ready),
    .cmd_can_receive (cmd_can_receive),
    .in_data         (in_data),
    .in_is_ready     (in_is_ready),
    .in_can_receive  (in_can_receive),
    .in_is_last      (in_is_last),
    .out_data        (out_data),
    .out_is_ready    (out_is_ready),
    .out_is_last     (out_is_last),
    .out_can_receive (out_can_receive)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference lane arithmetic
  //////////////////////////////////////////////////

  function automatic logic [63:0] lane_add(input logic [63:0] a, input logic [63:0] b);
    logic [63:0] s;
    for (int i = 0; i < 4; i++) begin
      s[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
    end
    return s;
  endfunction

  function automatic logic [63:0] lane_sub(input logic [63:0] a, input logic [63:0] b);
    logic [63:0] d;
    for (int i = 0; i < 4; i++) begin
      d[16*i +: 16] = a[16*i +: 16] - b[16*i +: 16];
    end
    return d;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input mem_and_mul_pkg::word_t got, input mem_and_mul_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_u(input mem_and_mul_pkg::u_word_t got, input mem_and_mul_pkg::u_word_t exp,
                         input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s last flag got %b expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %b expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic end_run();
    if (exp_data.size() != 0) begin
      $display("Run ended with %0d expected output words never received", exp_data.size());
      protocol_errors++;
    end
    $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Returns on the falling edge after the accepting edge
  task automatic send_cmd(input mem_and_mul_pkg::cmd_t c);
    @(negedge clk);
    cmd          = c;
    cmd_is_ready = 1'b1;
    while (!cmd_can_receive) @(negedge clk);
    @(negedge clk);
    cmd_is_ready = 1'b0;
  endtask

  task automatic load_rows(input mem_and_mul_pkg::cmd_t c);
    logic [63:0] w;
    send_cmd(c);
    for (int r = 0; r < model_rows; r++) begin
      w = lfsr_bits(lfsr_state, 64);
      case (c)
        mem_and_mul_pkg::in_u:  model_u[r] = w[15:0];
        mem_and_mul_pkg::add_c: model_c[r] = lane_add(model_c[r], w);
        default:                model_c[r] = w;
      endcase
      in_data     = w;
      in_is_ready = 1'b1;
      while (!in_can_receive) @(negedge clk);
      check_last(in_is_last, r == model_rows - 1, $sformatf("input row %0d", r));
      @(negedge clk);
    end
    in_is_ready = 1'b0;
  endtask

  task automatic run_op(input mem_and_mul_pkg::cmd_t c);
    send_cmd(c);
    for (int r = 0; r < model_rows; r++) begin
      case (c)
        mem_and_mul_pkg::enc_u_min_c: model_c[r] = lane_sub(ref_encode(model_u[r]), model_c[r]);
        mem_and_mul_pkg::enc_u:       model_c[r] = ref_encode(model_u[r]);
        default:                      model_u[r] = ref_decode(model_c[r]);
      endcase
    end
  endtask

  task automatic read_out(input mem_and_mul_pkg::cmd_t c);
    for (int r = 0; r < model_rows; r++) begin
      exp_data.push_back(c == mem_and_mul_pkg::out_u ? {48'h0, model_u[r]} : model_c[r]);
      exp_is_u.push_back(c == mem_and_mul_pkg::out_u);
      exp_row.push_back(r);
    end
    send_cmd(c);
    while (exp_data.size() != 0) @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Output checker and timeout
  //////////////////////////////////////////////////

  always @(posedge clk) begin : compare_outputs
    logic [63:0] w;
    logic        is_u;
    int          row;
    if (!reset && out_is_ready) begin
      if (exp_data.size() == 0) begin
        $display("Output transfer at %0t ns arrived with no word outstanding", $time);
        protocol_errors++;
      end else begin
        w    = exp_data.pop_front();
        is_u = exp_is_u.pop_front();
        row  = exp_row.pop_front();
        if (is_u) begin
          check_u(out_data[15:0], w[15:0], $sformatf("u row %0d", row));
          check_word({out_data[63:16], 16'h0}, 64'h0, $sformatf("u row %0d upper bits", row));
        end else begin
          check_word(out_data, w, $sformatf("C row %0d", row));
        end
        check_last(out_is_last, row == model_rows - 1, $sformatf("output row %0d", row));
      end
    end
  end

  // Random back-pressure on the output when enabled
  always @(negedge clk) begin : drive_out_ready
    logic [63:0] b;
    if (toggle_out) begin
      b               = lfsr_bits(lfsr_state, 1);
      out_can_receive = b[0];
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      protocol_errors++;
      end_run();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    cmd             = mem_and_mul_pkg::in_c;
    cmd_is_ready    = 1'b0;
    in_data         = '0;
    in_is_ready     = 1'b0;
    out_can_receive = 1'b1;
    toggle_out      = 1'b0;
    lfsr_state      = 16'd45;
    value_errors    = 0;
    protocol_errors = 0;
    cycles          = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // State right after reset
    check_flag(out_is_ready, 1'b0, "out_is_ready after reset");
    check_flag(in_can_receive, 1'b0, "in_can_receive after reset");
    check_flag(in_is_last, 1'b0, "in_is_last after reset");
    check_flag(cmd_can_receive, 1'b1, "cmd_can_receive after reset");

    load_rows(mem_and_mul_pkg::in_c);
    read_out(mem_and_mul_pkg::out_c);

    load_rows(mem_and_mul_pkg::add_c);
    read_out(mem_and_mul_pkg::out_c);

    load_rows(mem_and_mul_pkg::in_u);
    run_op(mem_and_mul_pkg::enc_u_min_c);
    read_out(mem_and_mul_pkg::out_c);

    // Decode of a random C, so rounding matters
    run_op(mem_and_mul_pkg::dec_c);
    read_out(mem_and_mul_pkg::out_u);

    run_op(mem_and_mul_pkg::enc_u);
    read_out(mem_and_mul_pkg::out_c);

    // Same C read back under random stalls
    @(posedge clk);
    toggle_out = 1'b1;
    read_out(mem_and_mul_pkg::out_c);
    toggle_out = 1'b0;
    @(negedge clk);
    out_can_receive = 1'b1;

    repeat (4) @(negedge clk);
    end_run();
  end

endmodule
